/* lsa_settings.svh */
// Build-time constants of the logic state analyzer, included by the RTL and the testbench
`ifndef LSA_SETTINGS_SVH
`define LSA_SETTINGS_SVH

// low address bits decoded inside the 4 kB register window
// the remaining upper ring address bits select the window itself
`define LSA_WINDOW_BITS 12

// log2 of the number of 32-bit words in the sample memory
// word 0 holds control/status and word 1 the live input in the address map
`define LSA_DEPTH_LOG2 10

// control values loaded into the ring-side register in the first cycle after reset
// an armed, unforced analyzer waits for the target trigger from power-up
`define LSA_INIT_ARMED 1
`define LSA_INIT_FORCED 0

// mode value handed to the debug target until the host writes its own
`define LSA_INIT_MODE 8'h00

`endif

/* rcn_bus_pkg.sv */
// Ring bus packet layout and bus operation type, shared by ring nodes and the testbench
package rcn_bus_pkg;

    // byte address carried on the ring
    typedef logic [23:0] rcn_addr_t;

    // kind of register access a request asks for
    typedef enum logic
    {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } rcn_op_e;

    // one 69-bit ring packet, most significant field first
    // a response keeps src_id so the master can match it to its request
    typedef struct packed
    {
        logic       valid;
        logic       req;
        logic       wr;
        logic [5:0] src_id;
        logic [3:0] mask;
        rcn_addr_t  addr;
        logic [31:0] data;
    } rcn_packet_t;

endpackage

/* lsa_pkg.sv */
// Analyzer types for the capture state machine and the register word map
`include "lsa_settings.svh"

package lsa_pkg;

    // capture progress in the sample clock domain
    typedef enum logic [1:0]
    {
        ST_IDLE      = 2'd0,
        ST_WAIT_TRIG = 2'd1,
        ST_FILL      = 2'd2,
        ST_DONE      = 2'd3
    } lsa_state_e;

    // word index inside the window
    // indices not listed here address the sample memory directly
    typedef enum logic [`LSA_DEPTH_LOG2-1:0]
    {
        REG_CTRL = `LSA_DEPTH_LOG2'd0,
        REG_LIVE = `LSA_DEPTH_LOG2'd1
    } lsa_reg_e;

endpackage

/* rcn_slave.sv */
// Three-stage ring node that turns requests for its window into register accesses and responses
`include "lsa_settings.svh"

module rcn_slave
    import rcn_bus_pkg::*;
#(
    parameter logic [23-`LSA_WINDOW_BITS:0] ADDR_BASE = 1
)
(
    input  logic        rcn_clk,
    input  logic        rcn_rst,
    input  rcn_packet_t rcn_in,
    output rcn_packet_t rcn_out,
    output logic        cs,
    output logic        wr,
    output rcn_addr_t   addr,
    output logic [31:0] wdata,
    input  logic [31:0] rdata
);

    rcn_packet_t in_q;
    rcn_packet_t mid_q;
    rcn_packet_t out_q;
    rcn_packet_t resp;
    rcn_op_e     op;
    rcn_op_e     mid_op;
    logic        hit;
    logic        mid_hit;

    // only live requests aimed at our window are taken, responses always pass
    assign hit = rcn_in.valid && rcn_in.req &&
                 (rcn_in.addr[23:`LSA_WINDOW_BITS] == ADDR_BASE);

    assign op = in_q.wr ? OP_WRITE : OP_READ;

    // the register access is presented straight from the first stage
    assign wr    = (op == OP_WRITE);
    assign addr  = in_q.addr;
    assign wdata = in_q.data;

    always_ff @(posedge rcn_clk or posedge rcn_rst)
    begin
        if (rcn_rst)
        begin
            in_q    <= '0;
            mid_q   <= '0;
            out_q   <= '0;
            cs      <= 1'b0;
            mid_hit <= 1'b0;
            mid_op  <= OP_READ;
        end
        else
        begin
            in_q    <= rcn_in;
            cs      <= hit;
            mid_q   <= in_q;
            mid_hit <= cs;
            mid_op  <= op;
            // by now the top has registered rdata for the access in stage two
            out_q   <= mid_hit ? resp : mid_q;
        end
    end

    // a response keeps the tag, write data is echoed back unchanged
    always_comb
    begin
        resp     = mid_q;
        resp.req = 1'b0;
        if (mid_op == OP_READ)
        begin
            resp.data = rdata;
        end
    end

    assign rcn_out = out_q;

endmodule

/* lsa_sync.sv */
// Toggle handshake carrying control into the sample clock domain and status back to the ring
module lsa_sync
(
    input  logic        rcn_clk,
    input  logic        lsa_clk,
    input  logic        rcn_rst,
    input  logic        ctrl_arm,
    input  logic        ctrl_force,
    input  logic [7:0]  ctrl_mode,
    output logic        lsa_arm,
    output logic        lsa_force,
    output logic [7:0]  lsa_mode,
    input  logic        sample_done,
    input  logic [31:0] sample_live,
    output logic        rcn_done,
    output logic [31:0] rcn_live
);

    // phase counter owned by the ring side and its copies in each domain
    logic [1:0]  sync_av;
    logic [1:0]  sync_lsa;
    logic [1:0]  sync_lsa_av;

    // ring-side hold of the outgoing control
    logic        rcn_arm;
    logic        rcn_force;
    logic [7:0]  rcn_mode;

    // sample-side hold of the returning status
    logic        lsa_done;
    logic [31:0] lsa_live;

    // the counter only moves on once the sample side has echoed its value back
    always_ff @(posedge rcn_clk or posedge rcn_rst)
    begin
        if (rcn_rst)
        begin
            sync_av <= 2'd0;
        end
        else if (sync_lsa_av == sync_av)
        begin
            sync_av <= sync_av + 2'd1;
        end
    end

    always_ff @(posedge rcn_clk)
    begin
        sync_lsa_av <= sync_lsa;
    end

    always_ff @(posedge lsa_clk)
    begin
        sync_lsa <= sync_av;
    end

    // phase 01 freezes control for the crossing and collects the last status
    always_ff @(posedge rcn_clk)
    begin
        if (sync_av == 2'b01)
        begin
            rcn_arm   <= ctrl_arm;
            rcn_force <= ctrl_force;
            rcn_mode  <= ctrl_mode;
            rcn_done  <= lsa_done;
            rcn_live  <= lsa_live;
        end
    end

    // phase 10 is seen here only while the ring side holds its values steady
    always_ff @(posedge lsa_clk)
    begin
        if (sync_lsa == 2'b10)
        begin
            lsa_arm   <= rcn_arm;
            lsa_force <= rcn_force;
            lsa_mode  <= rcn_mode;
            lsa_done  <= sample_done;
            lsa_live  <= sample_live;
        end
    end

endmodule

/* lsa_capture.sv */
// Sample-domain trigger state machine and sample memory with a read port on the ring clock
`include "lsa_settings.svh"

module lsa_capture
    import lsa_pkg::*;
(
    input  logic                       lsa_clk,
    input  logic                       rcn_clk,
    input  logic                       lsa_arm,
    input  logic                       lsa_force,
    input  logic                       lsa_trigger,
    input  logic [31:0]                lsa_data,
    output logic                       sample_done,
    input  logic [`LSA_DEPTH_LOG2-1:0] rd_index,
    output logic [31:0]                rd_data
);

    logic [31:0]                sample_mem [0:(1 << `LSA_DEPTH_LOG2) - 1];
    logic [`LSA_DEPTH_LOG2-1:0] waddr;
    lsa_state_e                 state;
    logic                       wr_en;

    // a disarmed analyzer falls back to idle and rewinds the write address to word 1
    always_ff @(posedge lsa_clk)
    begin
        if (!lsa_arm)
        begin
            state <= ST_IDLE;
            waddr <= `LSA_DEPTH_LOG2'd1;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    state <= ST_WAIT_TRIG;
                end
                ST_WAIT_TRIG:
                begin
                    // word 1 keeps the newest sample until the trigger arrives
                    if (lsa_trigger || lsa_force)
                    begin
                        state <= ST_FILL;
                        waddr <= `LSA_DEPTH_LOG2'd2;
                    end
                end
                ST_FILL:
                begin
                    if (waddr == '0)
                    begin
                        state <= ST_DONE;
                    end
                    else
                    begin
                        // runs past the top word and wraps to 0
                        waddr <= waddr + 1'b1;
                    end
                end
                ST_DONE:
                begin
                    state <= ST_DONE;
                end
                default:
                begin
                    state <= ST_IDLE;
                    waddr <= `LSA_DEPTH_LOG2'd1;
                end
            endcase
        end
    end

    assign wr_en       = lsa_arm && ((state == ST_WAIT_TRIG) || (state == ST_FILL));
    assign sample_done = (state == ST_DONE);

    always_ff @(posedge lsa_clk)
    begin
        if (wr_en)
        begin
            sample_mem[waddr] <= lsa_data;
        end
    end

    // ring-side read, one cycle of latency
    always_ff @(posedge rcn_clk)
    begin
        rd_data <= sample_mem[rd_index];
    end

endmodule

/* rcn_debug_lsa.sv */
// Top of the logic state analyzer ring slave, holding the control register and read data path
`include "lsa_settings.svh"

module rcn_debug_lsa
    import rcn_bus_pkg::*;
    import lsa_pkg::*;
#(
    parameter logic [23-`LSA_WINDOW_BITS:0] ADDR_BASE = 1
)
(
    input  logic        rcn_clk,
    input  logic        lsa_clk,
    input  logic        rcn_rst,
    input  rcn_packet_t rcn_in,
    output rcn_packet_t rcn_out,
    output logic [7:0]  lsa_mode,
    input  logic        lsa_trigger,
    input  logic [31:0] lsa_data
);

    logic                       bus_cs;
    logic                       bus_wr;
    rcn_addr_t                  bus_addr;
    logic [31:0]                bus_wdata;
    logic [31:0]                bus_rdata;
    logic [`LSA_DEPTH_LOG2-1:0] word_idx;

    logic                       init_done;
    logic                       ctrl_arm;
    logic                       ctrl_force;
    logic [7:0]                 ctrl_mode;
    logic [31:0]                ctrl_word;

    logic                       lsa_arm;
    logic                       lsa_force;
    logic                       sample_done;
    logic                       rcn_done;
    logic [31:0]                rcn_live;
    logic [31:0]                mem_rd_data;
    logic [31:0]                reg_rdata;
    logic                       mem_sel;

    rcn_slave #(
        .ADDR_BASE (ADDR_BASE)
    ) u_slave (
        .rcn_clk (rcn_clk),
        .rcn_rst (rcn_rst),
        .rcn_in  (rcn_in),
        .rcn_out (rcn_out),
        .cs      (bus_cs),
        .wr      (bus_wr),
        .addr    (bus_addr),
        .wdata   (bus_wdata),
        .rdata   (bus_rdata)
    );

    assign word_idx = bus_addr[`LSA_WINDOW_BITS-1:2];

    // reset clears the register, the following cycle loads the configured start values
    always_ff @(posedge rcn_clk or posedge rcn_rst)
    begin
        if (rcn_rst)
        begin
            init_done  <= 1'b0;
            ctrl_arm   <= 1'b0;
            ctrl_force <= 1'b0;
            ctrl_mode  <= 8'd0;
        end
        else if (!init_done)
        begin
            init_done  <= 1'b1;
            ctrl_arm   <= (`LSA_INIT_ARMED != 0);
            ctrl_force <= (`LSA_INIT_FORCED != 0);
            ctrl_mode  <= `LSA_INIT_MODE;
        end
        else if (bus_cs && bus_wr && (word_idx == REG_CTRL))
        begin
            ctrl_arm   <= bus_wdata[0];
            ctrl_force <= bus_wdata[1];
            ctrl_mode  <= bus_wdata[15:8];
        end
    end

    // done is read only and arrives through the crossing
    assign ctrl_word = {16'd0, ctrl_mode, 5'd0, rcn_done, ctrl_force, ctrl_arm};

    lsa_sync u_sync (
        .rcn_clk     (rcn_clk),
        .lsa_clk     (lsa_clk),
        .rcn_rst     (rcn_rst),
        .ctrl_arm    (ctrl_arm),
        .ctrl_force  (ctrl_force),
        .ctrl_mode   (ctrl_mode),
        .lsa_arm     (lsa_arm),
        .lsa_force   (lsa_force),
        .lsa_mode    (lsa_mode),
        .sample_done (sample_done),
        .sample_live (lsa_data),
        .rcn_done    (rcn_done),
        .rcn_live    (rcn_live)
    );

    lsa_capture u_capture (
        .lsa_clk     (lsa_clk),
        .rcn_clk     (rcn_clk),
        .lsa_arm     (lsa_arm),
        .lsa_force   (lsa_force),
        .lsa_trigger (lsa_trigger),
        .lsa_data    (lsa_data),
        .sample_done (sample_done),
        .rd_index    (word_idx),
        .rd_data     (mem_rd_data)
    );

    // register words and the memory port are both sampled at the end of the cs cycle
    always_ff @(posedge rcn_clk)
    begin
        mem_sel <= 1'b0;
        case (word_idx)
            REG_CTRL: reg_rdata <= ctrl_word;
            REG_LIVE: reg_rdata <= rcn_live;
            default:
            begin
                reg_rdata <= 32'd0;
                mem_sel   <= 1'b1;
            end
        endcase
    end

    assign bus_rdata = mem_sel ? mem_rd_data : reg_rdata;

endmodule

/* lsa_tb.sv */
// Testbench for the ring-bus logic state analyzer, replaying the host operations of lsa_tb_input.txt
`include "lsa_settings.svh"

module lsa_tb
    import rcn_bus_pkg::*;
    import lsa_pkg::*;
();

    localparam logic [23-`LSA_WINDOW_BITS:0] WINDOW = 'h0a5;
    localparam int TOP_WORD   = (1 << `LSA_DEPTH_LOG2) - 1;
    localparam int OP_MAX     = 64;
    localparam int RESP_LIMIT = 20;
    localparam int POLL_LIMIT = 4000;
    localparam int MODE_LIMIT = 200;

    logic        rcn_clk;
    logic        lsa_clk;
    logic        rcn_rst;
    rcn_packet_t rcn_in;
    rcn_packet_t rcn_out;
    logic [7:0]  lsa_mode;
    logic        lsa_trigger;
    logic [31:0] lsa_data;

    logic [31:0] ops [0:5*OP_MAX-1];
    logic [31:0] sample_count;
    logic        hold;
    logic [31:0] hold_value;
    logic        trig_armed;
    logic [31:0] trig_count;
    integer      seed;
    logic [5:0]  last_id;
    int          errors;
    int          timeouts;

    rcn_debug_lsa #(
        .ADDR_BASE (WINDOW)
    ) UUT (
        .rcn_clk     (rcn_clk),
        .lsa_clk     (lsa_clk),
        .rcn_rst     (rcn_rst),
        .rcn_in      (rcn_in),
        .rcn_out     (rcn_out),
        .lsa_mode    (lsa_mode),
        .lsa_trigger (lsa_trigger),
        .lsa_data    (lsa_data)
    );

    always #5 lsa_clk = ~lsa_clk;
    always #7 rcn_clk = ~rcn_clk;

    // the debug target counts every sample cycle and pulses its trigger once the count hits T
    always @(posedge lsa_clk)
    begin
        #1;
        sample_count = sample_count + 32'd1;
        lsa_data     = hold ? hold_value : sample_count;
        lsa_trigger  = trig_armed && (sample_count == trig_count);
    end

    function automatic rcn_addr_t word_addr(input int n);
        word_addr = {WINDOW, n[`LSA_WINDOW_BITS-3:0], 2'b00};
    endfunction

    task automatic check_packet(input string name, input rcn_packet_t expected,
                                input rcn_packet_t actual);
        if (actual !== expected)
        begin
            $display("** Error at %0t: %s expected %h, actual %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("** Error at %0t: %s expected %h, actual %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    // one request on the ring, then wait for the packet that carries our tag
    task automatic ring_access(input rcn_op_e op, input rcn_addr_t addr, input logic [31:0] wdata,
                               output rcn_packet_t sent, output rcn_packet_t rsp);
        int         cycles;
        logic [5:0] id;
        id = 6'($random(seed));
        if (id == last_id)
            id = id + 6'd1;
        last_id     = id;
        sent        = '0;
        sent.valid  = 1'b1;
        sent.req    = 1'b1;
        sent.wr     = (op == OP_WRITE);
        sent.src_id = id;
        sent.mask   = 4'hf;
        sent.addr   = addr;
        sent.data   = wdata;
        rsp         = '0;
        @(posedge rcn_clk);
        #1;
        rcn_in = sent;
        @(posedge rcn_clk);
        #1;
        rcn_in = '0;
        cycles = 0;
        do
        begin
            @(negedge rcn_clk);
            cycles++;
        end
        while (!(rcn_out.valid === 1'b1 && rcn_out.src_id === id) && cycles < RESP_LIMIT);
        if (rcn_out.valid === 1'b1 && rcn_out.src_id === id)
            rsp = rcn_out;
        else
        begin
            $display("Timeout: no ring response with tag %0d for address %h", id, addr);
            timeouts++;
        end
    endtask

    // the header is checked here, the caller judges the data
    task automatic read_word(input rcn_addr_t addr, output logic [31:0] data);
        rcn_packet_t sent;
        rcn_packet_t rsp;
        rcn_packet_t expected;
        ring_access(OP_READ, addr, 32'd0, sent, rsp);
        data          = rsp.data;
        expected      = sent;
        expected.req  = 1'b0;
        expected.data = '0;
        rsp.data      = '0;
        check_packet("rcn_out header", expected, rsp);
    endtask

    task automatic write_word(input rcn_addr_t addr, input logic [31:0] wdata);
        rcn_packet_t sent;
        rcn_packet_t rsp;
        rcn_packet_t expected;
        ring_access(OP_WRITE, addr, wdata, sent, rsp);
        expected     = sent;
        expected.req = 1'b0;
        check_packet("rcn_out", expected, rsp);
    endtask

    // a request outside our window has to come back exactly as it was sent
    task automatic pass_through(input rcn_addr_t addr);
        rcn_packet_t sent;
        rcn_packet_t rsp;
        ring_access(OP_READ, addr, 32'h0bad_f00d, sent, rsp);
        check_packet("rcn_out", sent, rsp);
    endtask

    task automatic poll_read(input rcn_addr_t addr, input logic [31:0] expected,
                             input logic [31:0] mask);
        int          tries;
        logic [31:0] data;
        tries = 0;
        do
        begin
            read_word(addr, data);
            tries++;
        end
        while (((data & mask) !== (expected & mask)) && tries < POLL_LIMIT);
        if ((data & mask) !== (expected & mask))
        begin
            $display("Timeout: word at %h never showed %h under mask %h", addr, expected, mask);
            timeouts++;
        end
    endtask

    task automatic wait_mode(input logic [7:0] expected);
        int cycles;
        cycles = 0;
        do
        begin
            @(negedge lsa_clk);
            cycles++;
        end
        while (lsa_mode !== expected && cycles < MODE_LIMIT);
        if (lsa_mode !== expected)
        begin
            $display("Timeout: lsa_mode never reached %h", expected);
            timeouts++;
        end
    endtask

    // word 1 sits under REG_LIVE in the map, so the readable run starts at word 2
    task automatic check_sample_run();
        logic [31:0] prev;
        logic [31:0] data;
        read_word(word_addr(int'(REG_LIVE) + 1), prev);
        for (int n = int'(REG_LIVE) + 2; n <= TOP_WORD; n++)
        begin
            read_word(word_addr(n), data);
            check_word($sformatf("sample word %0d", n), prev + 32'd1, data);
            prev = data;
        end
    endtask

    initial
    begin
        int          i;
        logic [31:0] op;
        rcn_addr_t   addr;
        logic [31:0] wdata;
        logic [31:0] expected;
        logic [31:0] mask;
        logic [31:0] data;
        rcn_clk      = 1'b0;
        lsa_clk      = 1'b0;
        rcn_rst      = 1'b1;
        rcn_in       = '0;
        lsa_trigger  = 1'b0;
        lsa_data     = 32'd0;
        sample_count = 32'd0;
        hold         = 1'b0;
        hold_value   = 32'd0;
        trig_armed   = 1'b0;
        trig_count   = 32'd0;
        seed         = 32'hbc1d_04e0;
        last_id      = 6'd0;
        errors       = 0;
        timeouts     = 0;
        $readmemh("lsa_tb_input.txt", ops);
        repeat (10) @(posedge rcn_clk);
        #1;
        rcn_rst = 1'b0;
        i = 0;
        while (i < OP_MAX && !$isunknown(ops[5*i]) && ops[5*i] != 32'hf)
        begin
            op       = ops[5*i];
            addr     = ops[5*i+1][23:0];
            wdata    = ops[5*i+2];
            expected = ops[5*i+3];
            mask     = ops[5*i+4];
            case (op)
                32'h0:
                begin
                    read_word(addr, data);
                    check_word($sformatf("rcn_out.data @%h", addr), expected & mask, data & mask);
                end
                32'h1: write_word(addr, wdata);
                32'h2: poll_read(addr, expected, mask);
                32'h3: wait_mode(expected[7:0]);
                32'h4:
                begin
                    hold_value = wdata;
                    hold       = 1'b1;
                end
                32'h5: hold = 1'b0;
                32'h6:
                begin
                    trig_count = wdata;
                    trig_armed = 1'b1;
                end
                32'h7: check_sample_run();
                32'h8: pass_through(addr);
                default:
                begin
                    $display("Unknown operation %h on entry %0d of the data file", op, i);
                    errors++;
                end
            endcase
            i++;
        end
        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

/* lsa_tb_input.txt */
// columns: op, ring address, write data, expected value, compare mask (all hex)
// ops: 0 read 1 write 2 poll 3 mode wait 4 hold 5 release 6 trigger at 7 run 8 foreign f end
4 000000 00c0ffee 00000000 00000000
0 0a5000 00000000 00000001 0000ff03
8 123004 00000000 00000000 00000000
8 0a4ffc 00000000 00000000 00000000
1 0a5000 00005a01 00000000 00000000
3 000000 00000000 0000005a 000000ff
0 0a5000 00000000 00005a01 0000ff03
0 0a5004 00000000 00c0ffee ffffffff
5 000000 00000000 00000000 00000000
1 0a5000 00005a03 00000000 00000000
2 0a5000 00000000 00000004 00000004
7 000000 00000000 00000000 00000000
1 0a5000 00005a00 00000000 00000000
2 0a5000 00000000 00000000 00000004
6 000000 00004000 00000000 00000000
1 0a5000 00005a01 00000000 00000000
2 0a5000 00000000 00000004 00000004
0 0a5008 00000000 00004001 ffffffff
0 0a500c 00000000 00004002 ffffffff
0 0a5000 00000000 00005a05 0000ff07
f 000000 00000000 00000000 00000000

/* sources.f */
+incdir+.
rcn_bus_pkg.sv
lsa_pkg.sv
rcn_slave.sv
lsa_sync.sv
lsa_capture.sv
rcn_debug_lsa.sv
lsa_tb.sv
